//--- mult_pkg.sv
`default_nettype none

package mult_pkg;

    localparam int unsigned ARCH_WIDTH   = 32;
    localparam int unsigned ARCH_WIDTH_D = 2 * ARCH_WIDTH;  // full product
    localparam int unsigned ARCH_WIDTH_H = ARCH_WIDTH / 2;  // dot16 lane
    localparam int unsigned AXI_ADDR_W   = 5;

    typedef logic [ARCH_WIDTH-1:0] simd_t;        // operand or result word
    typedef simd_t [1:0] simd_d_t;                // [1] high word, [0] low word
    typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
    typedef logic [ARCH_WIDTH/8-1:0] axi_strb_t;  // one bit per byte lane
    typedef logic [1:0] axi_resp_t;

    // bit 2 set for the packed lane ops
    typedef enum logic [2:0] {
        MULT_OP_MUL    = 3'd0,  // low word, signed
        MULT_OP_MULH   = 3'd1,  // high word, signed x signed
        MULT_OP_MULHSU = 3'd2,  // high word, signed a x unsigned b
        MULT_OP_MULHU  = 3'd3,  // high word, unsigned
        MULT_OP_DOT16  = 3'd4,  // 2 lanes of 16x16 summed
        MULT_OP_DOT8   = 3'd5   // 4 lanes of 8x8 summed, 17-bit result
    } mult_op_t;

    // register map, byte offsets
    localparam axi_addr_t REG_A      = 5'h00;
    localparam axi_addr_t REG_B      = 5'h04;
    localparam axi_addr_t REG_CTRL   = 5'h08;  // write starts an op
    localparam axi_addr_t REG_RESULT = 5'h0C;
    localparam axi_addr_t REG_STATUS = 5'h10;  // [1] busy, [0] done

    localparam axi_resp_t AXI_RESP_OKAY = 2'b00;
    localparam axi_strb_t AXI_STRB_FULL = '1;  // only full words get written

endpackage

`default_nettype wire

//--- mult_if.sv
`timescale 1ns/1ns
`default_nettype none

interface mult_if import mult_pkg::*; ();

    logic     valid;    // start strobe, one cycle per request
    mult_op_t op;
    simd_t    a;
    simd_t    b;
    simd_t    p;        // result, good only while p_valid
    logic     p_valid;

    // register block side
    modport host (
        output valid, op, a, b,
        input  p, p_valid
    );

    // multiplier side
    modport core (
        input  valid, op, a, b,
        output p, p_valid
    );

endinterface

`default_nettype wire

//--- csa_tree_8.sv
`timescale 1ns/1ns
`default_nettype none

module csa_tree_8 #(
    parameter int unsigned W = 64
) (
    input  logic [7:0][W-1:0] i_a,
    output logic [W-1:0]      o_s,
    output logic [W-1:0]      o_c   // already weighted, just add to o_s
);

    // row of full adders, [0] sum, [1] carry moved up one bit
    function automatic logic [1:0][W-1:0] csa_3_2(
        input logic [W-1:0] x,
        input logic [W-1:0] y,
        input logic [W-1:0] z
    );
        logic [1:0][W-1:0] r;
        r[0] = x ^ y ^ z;
        r[1] = ((x & y) | (x & z) | (y & z)) << 1;  // top carry drops off, mod 2^W
        return r;
    endfunction

    logic [5:0][W-1:0] lvl_1;  // 8 -> 6
    logic [3:0][W-1:0] lvl_2;  // 6 -> 4
    logic [2:0][W-1:0] lvl_3;  // 4 -> 3
    logic [1:0][W-1:0] lvl_4;  // 3 -> 2

    // level 1, two compressors, last pair waits a level
    assign lvl_1[1:0] = csa_3_2(i_a[0], i_a[1], i_a[2]);
    assign lvl_1[3:2] = csa_3_2(i_a[3], i_a[4], i_a[5]);
    assign lvl_1[5:4] = i_a[7:6];

    // level 2
    assign lvl_2[1:0] = csa_3_2(lvl_1[0], lvl_1[1], lvl_1[2]);
    assign lvl_2[3:2] = csa_3_2(lvl_1[3], lvl_1[4], lvl_1[5]);

    // level 3, one word rides along
    assign lvl_3[1:0] = csa_3_2(lvl_2[0], lvl_2[1], lvl_2[2]);
    assign lvl_3[2]   = lvl_2[3];

    // level 4
    assign lvl_4 = csa_3_2(lvl_3[0], lvl_3[1], lvl_3[2]);

    assign o_s = lvl_4[0];
    assign o_c = lvl_4[1];

endmodule

`default_nettype wire

//--- simd_mult.sv
`timescale 1ns/1ns
`default_nettype none

module simd_mult import mult_pkg::*; #(
    parameter int unsigned TREE_W = ARCH_WIDTH_D  // csa word width
) (
    input  logic clk,
    input  logic i_rst,
    mult_if.core mul
);

    localparam int unsigned LANE_8    = 8;
    localparam int unsigned LANE_16   = ARCH_WIDTH_H;
    localparam int unsigned DOT8_W    = ARCH_WIDTH_H + 1;    // dot8 sum, 17 bits
    localparam int unsigned DOT8_SIGN = ARCH_WIDTH - DOT8_W; // sign pad, 15 bits

    // trees must hold the whole 64-bit product
    if (TREE_W < ARCH_WIDTH_D) begin : g_tree_w_check
        $error("simd_mult: TREE_W narrower than the double word");
    end

    logic op_dot16;
    logic op_dot8;
    logic op_simd;
    logic op_ok;
    assign op_dot16 = (mul.op == MULT_OP_DOT16);
    assign op_dot8  = (mul.op == MULT_OP_DOT8);
    assign op_simd  = mul.op[2];
    assign op_ok    = mul.op inside {MULT_OP_MUL, MULT_OP_MULH, MULT_OP_MULHSU,
                                     MULT_OP_MULHU, MULT_OP_DOT16, MULT_OP_DOT8};

    // AND matrix, row i = a[i] & b, lane-aware Baugh-Wooley
    simd_t [ARCH_WIDTH-1:0] pp;
    always_comb begin
        logic bit_ij;
        logic in_tile;  // (i, j) sits on a diagonal lane tile
        logic row_sgn;  // lane-local sign row
        logic col_sgn;  // lane-local sign column
        for (int i = 0; i < ARCH_WIDTH; i++) begin
            for (int j = 0; j < ARCH_WIDTH; j++) begin
                if (op_dot8) begin
                    in_tile = (i / LANE_8) == (j / LANE_8);
                    row_sgn = (i % LANE_8) == LANE_8 - 1;
                    col_sgn = (j % LANE_8) == LANE_8 - 1;
                end else if (op_dot16) begin
                    in_tile = (i / LANE_16) == (j / LANE_16);
                    row_sgn = (i % LANE_16) == LANE_16 - 1;
                    col_sgn = (j % LANE_16) == LANE_16 - 1;
                end else begin
                    in_tile = 1'b1;  // one 32x32 lane
                    row_sgn = (i == ARCH_WIDTH - 1);
                    col_sgn = (j == ARCH_WIDTH - 1);
                end
                bit_ij = mul.a[i] & mul.b[j];
                // invert sign row and column, corner stays, MULHU stays plain
                if ((mul.op != MULT_OP_MULHU) && (row_sgn != col_sgn)) begin
                    bit_ij = ~bit_ij;
                end
                pp[i][j] = bit_ij & in_tile & op_ok;  // bad op code, empty matrix
            end
        end
    end

    // weight each row, lane rows are pulled back down to bit 0 for the sum
    logic [ARCH_WIDTH-1:0][TREE_W-1:0] ppv;
    always_comb begin
        for (int i = 0; i < ARCH_WIDTH; i++) begin
            if (op_dot8) begin
                ppv[i] = (TREE_W'(pp[i]) << (i % LANE_8)) >> ((i / LANE_8) * LANE_8);
            end else if (op_dot16) begin
                ppv[i] = (TREE_W'(pp[i]) << (i % LANE_16)) >> ((i / LANE_16) * LANE_16);
            end else begin
                ppv[i] = TREE_W'(pp[i]) << i;
            end
        end
    end

    // Baugh-Wooley constant per mode
    simd_d_t corr;
    always_comb begin
        case (mul.op)
            MULT_OP_MUL,
            MULT_OP_MULH,
            MULT_OP_MULHSU: corr = 64'h8000_0001_0000_0000;  // 2^63 + 2^32
            MULT_OP_DOT16:  corr = 64'h0000_0000_0002_0000;  // 2^16, once per lane
            MULT_OP_DOT8:   corr = 64'h0000_0000_0000_0400;  // 2^8, four lanes
            default:        corr = '0;                       // MULHU, bad codes
        endcase
    end

    // stage one trees, 8 rows each, [2t] sum, [2t+1] carry
    logic [7:0][TREE_W-1:0] tree_o;
    for (genvar t = 0; t < 4; t++) begin : g_tree
        csa_tree_8 #(.W(TREE_W)) csa_tree_8_i (
            .i_a (ppv[8*t +: 8]),
            .o_s (tree_o[2*t]),
            .o_c (tree_o[2*t+1])
        );
    end

    logic [7:0][TREE_W-1:0] tree_d;
    mult_op_t               op_d;
    simd_d_t                corr_d;
    simd_t                  a_d;
    logic                   b_sgn_d;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            op_d        <= MULT_OP_MUL;
            mul.p_valid <= 1'b0;
        end else begin
            mul.p_valid <= mul.valid;
            if (mul.valid) begin
                op_d <= op_ok ? mul.op : MULT_OP_MUL;  // bad code runs as MUL of zero
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mul.valid) begin
            tree_d <= tree_o;
            corr_d <= corr;
        end
        if (mul.valid && !op_simd) begin  // only MULHSU reads these
            a_d     <= mul.a;
            b_sgn_d <= mul.b[ARCH_WIDTH-1];
        end
    end

    // stage two, final tree then carry-propagate
    logic [TREE_W-1:0] tree_f_s;
    logic [TREE_W-1:0] tree_f_c;
    logic [TREE_W-1:0] tree_sum;
    simd_d_t           mul_s;
    simd_t             mul_su;

    csa_tree_8 #(.W(TREE_W)) csa_tree_8_f_i (
        .i_a (tree_d),
        .o_s (tree_f_s),
        .o_c (tree_f_c)
    );

    assign tree_sum = tree_f_s + tree_f_c;
    assign mul_s    = tree_sum[ARCH_WIDTH_D-1:0] + corr_d;
    // b taken unsigned adds a * 2^32 when its sign bit is set
    assign mul_su   = b_sgn_d ? (mul_s[1] + a_d) : mul_s[1];

    always_comb begin
        case (op_d)
            MULT_OP_MUL:    mul.p = mul_s[0];
            MULT_OP_MULH:   mul.p = mul_s[1];
            MULT_OP_MULHSU: mul.p = mul_su;
            MULT_OP_MULHU:  mul.p = mul_s[1];  // no flips, no constant
            MULT_OP_DOT16:  mul.p = mul_s[0];  // lane sums already overlap
            MULT_OP_DOT8:   mul.p = {{DOT8_SIGN{mul_s[0][DOT8_W-1]}}, mul_s[0][DOT8_W-1:0]};
            default:        mul.p = '0;
        endcase
    end

    // result strobe trails the request by exactly one cycle
    a_p_valid_timing: assert property (@(posedge clk) disable iff (i_rst)
        mul.p_valid == $past(mul.valid));

    // bad codes were folded to MUL at the stage register
    a_p_valid_op: assert property (@(posedge clk) disable iff (i_rst)
        mul.p_valid |-> op_d inside {MULT_OP_MUL, MULT_OP_MULH, MULT_OP_MULHSU,
                                     MULT_OP_MULHU, MULT_OP_DOT16, MULT_OP_DOT8});

endmodule

`default_nettype wire

//--- mult_axil_regs.sv
`timescale 1ns/1ns
`default_nettype none

module mult_axil_regs import mult_pkg::*; (
    input  logic      clk,
    input  logic      i_rst,
    input  axi_addr_t i_s_axi_awaddr,
    input  logic      i_s_axi_awvalid,
    output logic      o_s_axi_awready,
    input  simd_t     i_s_axi_wdata,
    input  axi_strb_t i_s_axi_wstrb,
    input  logic      i_s_axi_wvalid,
    output logic      o_s_axi_wready,
    output axi_resp_t o_s_axi_bresp,
    output logic      o_s_axi_bvalid,
    input  logic      i_s_axi_bready,
    input  axi_addr_t i_s_axi_araddr,
    input  logic      i_s_axi_arvalid,
    output logic      o_s_axi_arready,
    output simd_t     o_s_axi_rdata,
    output axi_resp_t o_s_axi_rresp,
    output logic      o_s_axi_rvalid,
    input  logic      i_s_axi_rready,
    mult_if.host      mul
);

    typedef enum logic [1:0] {W_IDLE, W_DATA, W_ADDR, W_RESP} wr_state_t;
    typedef enum logic {R_IDLE, R_RESP} rd_state_t;

    wr_state_t  wr_state;
    wr_state_t  wr_next;
    rd_state_t  rd_state;
    rd_state_t  rd_next;
    logic       aw_hs;
    logic       w_hs;
    logic       ar_hs;
    logic       wr_en;       // write lands this cycle
    axi_addr_t  awaddr_q;
    simd_t      wdata_q;
    axi_strb_t  wstrb_q;
    axi_addr_t  wr_addr;
    simd_t      wr_data;
    axi_strb_t  wr_strb;
    simd_t      reg_a;
    simd_t      reg_b;
    simd_t      reg_result;
    logic       done;
    logic       busy;
    logic [1:0] in_flight;   // 0..2 requests in the pipe
    simd_t      rd_word;

    assign aw_hs = i_s_axi_awvalid & o_s_axi_awready;
    assign w_hs  = i_s_axi_wvalid & o_s_axi_wready;
    assign ar_hs = i_s_axi_arvalid & o_s_axi_arready;

    always_comb begin
        wr_next = wr_state;
        case (wr_state)
            W_IDLE: begin
                if (aw_hs && w_hs) begin
                    wr_next = W_RESP;
                end else if (aw_hs) begin
                    wr_next = W_DATA;  // hold addr, wait for data
                end else if (w_hs) begin
                    wr_next = W_ADDR;  // hold data, wait for addr
                end
            end
            W_DATA:  if (w_hs) wr_next = W_RESP;
            W_ADDR:  if (aw_hs) wr_next = W_RESP;
            default: if (i_s_axi_bready) wr_next = W_IDLE;
        endcase
    end

    always_comb begin
        rd_next = rd_state;
        case (rd_state)
            R_IDLE:  if (ar_hs) rd_next = R_RESP;
            default: if (i_s_axi_rready) rd_next = R_IDLE;
        endcase
    end

    // the half that arrived earlier comes from its holding register
    assign wr_en   = (wr_state != W_RESP) && (wr_next == W_RESP);
    assign wr_addr = aw_hs ? i_s_axi_awaddr : awaddr_q;
    assign wr_data = w_hs ? i_s_axi_wdata : wdata_q;
    assign wr_strb = w_hs ? i_s_axi_wstrb : wstrb_q;

    // readies and valids registered off the next state
    always_ff @(posedge clk) begin
        if (i_rst) begin
            wr_state        <= W_IDLE;
            rd_state        <= R_IDLE;
            o_s_axi_awready <= 1'b0;
            o_s_axi_wready  <= 1'b0;
            o_s_axi_bvalid  <= 1'b0;
            o_s_axi_arready <= 1'b0;
            o_s_axi_rvalid  <= 1'b0;
        end else begin
            wr_state        <= wr_next;
            rd_state        <= rd_next;
            o_s_axi_awready <= (wr_next == W_IDLE) || (wr_next == W_ADDR);
            o_s_axi_wready  <= (wr_next == W_IDLE) || (wr_next == W_DATA);
            o_s_axi_bvalid  <= (wr_next == W_RESP);
            o_s_axi_arready <= (rd_next == R_IDLE);  // low while R is stalled
            o_s_axi_rvalid  <= (rd_next == R_RESP);
        end
    end

    always_ff @(posedge clk) begin
        if (aw_hs) awaddr_q <= i_s_axi_awaddr;
        if (w_hs) begin
            wdata_q <= i_s_axi_wdata;
            wstrb_q <= i_s_axi_wstrb;
        end
        if (ar_hs) o_s_axi_rdata <= rd_word;  // held through back-pressure
    end

    assign o_s_axi_bresp = AXI_RESP_OKAY;
    assign o_s_axi_rresp = AXI_RESP_OKAY;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            reg_a      <= '0;
            reg_b      <= '0;
            reg_result <= '0;
            done       <= 1'b0;
            in_flight  <= '0;
            mul.valid  <= 1'b0;
            mul.op     <= MULT_OP_MUL;
        end else begin
            mul.valid <= 1'b0;
            if (wr_en && (wr_strb == AXI_STRB_FULL)) begin
                case (wr_addr)
                    REG_A: reg_a <= wr_data;
                    REG_B: reg_b <= wr_data;
                    REG_CTRL: begin
                        mul.valid <= 1'b1;  // next cycle is the start
                        mul.op    <= mult_op_t'(wr_data[2:0]);
                    end
                    default: ;  // result and status are read only
                endcase
            end
            if (mul.p_valid) reg_result <= mul.p;
            if (mul.valid) begin
                done <= 1'b0;  // new start wins over an older completion
            end else if (mul.p_valid) begin
                done <= 1'b1;
            end
            case ({mul.valid, mul.p_valid})
                2'b10:   in_flight <= in_flight + 2'd1;
                2'b01:   in_flight <= in_flight - 2'd1;
                default: in_flight <= in_flight;
            endcase
        end
    end

    assign busy  = (in_flight != 2'd0);
    assign mul.a = reg_a;
    assign mul.b = reg_b;

    always_comb begin
        case (i_s_axi_araddr)
            REG_A:      rd_word = reg_a;
            REG_B:      rd_word = reg_b;
            REG_CTRL:   rd_word = simd_t'(mul.op);
            REG_RESULT: rd_word = reg_result;
            REG_STATUS: rd_word = simd_t'({busy, done});
            default:    rd_word = '0;  // holes read zero
        endcase
    end

    // write response held until the master takes it
    a_bvalid_hold: assert property (@(posedge clk) disable iff (i_rst)
        o_s_axi_bvalid && !i_s_axi_bready |=> o_s_axi_bvalid);

endmodule

`default_nettype wire

//--- mult_top.sv
`timescale 1ns/1ns
`default_nettype none

module mult_top import mult_pkg::*; #(
    parameter int unsigned TREE_W = ARCH_WIDTH_D  // csa word width in the multiplier
) (
    input  logic      clk,
    input  logic      i_rst,
    input  axi_addr_t i_s_axi_awaddr,
    input  logic      i_s_axi_awvalid,
    output logic      o_s_axi_awready,
    input  simd_t     i_s_axi_wdata,
    input  axi_strb_t i_s_axi_wstrb,
    input  logic      i_s_axi_wvalid,
    output logic      o_s_axi_wready,
    output axi_resp_t o_s_axi_bresp,
    output logic      o_s_axi_bvalid,
    input  logic      i_s_axi_bready,
    input  axi_addr_t i_s_axi_araddr,
    input  logic      i_s_axi_arvalid,
    output logic      o_s_axi_arready,
    output simd_t     o_s_axi_rdata,
    output axi_resp_t o_s_axi_rresp,
    output logic      o_s_axi_rvalid,
    input  logic      i_s_axi_rready
);

    mult_if mul_if ();  // request in, result out

    mult_axil_regs regs_i (
        .clk             (clk),
        .i_rst           (i_rst),
        .i_s_axi_awaddr  (i_s_axi_awaddr),
        .i_s_axi_awvalid (i_s_axi_awvalid),
        .o_s_axi_awready (o_s_axi_awready),
        .i_s_axi_wdata   (i_s_axi_wdata),
        .i_s_axi_wstrb   (i_s_axi_wstrb),
        .i_s_axi_wvalid  (i_s_axi_wvalid),
        .o_s_axi_wready  (o_s_axi_wready),
        .o_s_axi_bresp   (o_s_axi_bresp),
        .o_s_axi_bvalid  (o_s_axi_bvalid),
        .i_s_axi_bready  (i_s_axi_bready),
        .i_s_axi_araddr  (i_s_axi_araddr),
        .i_s_axi_arvalid (i_s_axi_arvalid),
        .o_s_axi_arready (o_s_axi_arready),
        .o_s_axi_rdata   (o_s_axi_rdata),
        .o_s_axi_rresp   (o_s_axi_rresp),
        .o_s_axi_rvalid  (o_s_axi_rvalid),
        .i_s_axi_rready  (i_s_axi_rready),
        .mul             (mul_if.host)
    );

    // two-stage core, result one cycle after the start
    simd_mult #(.TREE_W(TREE_W)) mult_i (
        .clk   (clk),
        .i_rst (i_rst),
        .mul   (mul_if.core)
    );

endmodule

`default_nettype wire

//--- tb_mult_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mult_top import mult_pkg::*; ();

    localparam int CLK_PERIOD = 40;
    localparam int RST_CYCLES = 16;
    localparam int N_SCALAR   = 24;  // six rounds of the four scalar ops
    localparam int N_DOT      = 12;
    localparam int N_B2B      = 4;
    localparam int N_STALL    = 12;
    localparam int N_TESTS    = 1 + N_SCALAR + N_DOT + 2 + N_B2B + N_STALL;
    localparam int WD_CYCLES  = N_TESTS * 200 + RST_CYCLES;
    localparam int MAX_POLLS  = 4;   // status reads before giving up on done

    logic      clk;
    logic      i_rst;
    axi_addr_t awaddr;
    logic      awvalid;
    logic      awready;
    simd_t     wdata;
    axi_strb_t wstrb;
    logic      wvalid;
    logic      wready;
    axi_resp_t bresp;
    logic      bvalid;
    logic      bready;
    axi_addr_t araddr;
    logic      arvalid;
    logic      arready;
    simd_t     rdata;
    axi_resp_t rresp;
    logic      rvalid;
    logic      rready;

    integer seed;
    int     errors;
    int     pass_count;
    int     fail_count;
    bit     stall_en;    // random BREADY / RREADY stretches
    string  test_name;

    mult_top #(.TREE_W(ARCH_WIDTH_D)) dut_i (
        .clk (clk), .i_rst (i_rst),
        .i_s_axi_awaddr (awaddr), .i_s_axi_awvalid (awvalid), .o_s_axi_awready (awready),
        .i_s_axi_wdata (wdata), .i_s_axi_wstrb (wstrb), .i_s_axi_wvalid (wvalid),
        .o_s_axi_wready (wready),
        .o_s_axi_bresp (bresp), .o_s_axi_bvalid (bvalid), .i_s_axi_bready (bready),
        .i_s_axi_araddr (araddr), .i_s_axi_arvalid (arvalid), .o_s_axi_arready (arready),
        .o_s_axi_rdata (rdata), .o_s_axi_rresp (rresp), .o_s_axi_rvalid (rvalid),
        .i_s_axi_rready (rready)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // expected result straight from the op definitions
    function automatic simd_t ref_result(input logic [2:0] op, input simd_t a, input simd_t b);
        logic [63:0] sa;
        logic [63:0] sb;
        logic [63:0] za;
        logic [63:0] zb;
        logic [63:0] prod;
        int          lane_sum;
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        za = {32'h0, a};
        zb = {32'h0, b};
        lane_sum = 0;
        case (op)
            3'd0: begin  // MUL
                prod       = sa * sb;
                ref_result = prod[31:0];
            end
            3'd1: begin  // MULH
                prod       = sa * sb;
                ref_result = prod[63:32];
            end
            3'd2: begin  // MULHSU
                prod       = sa * zb;
                ref_result = prod[63:32];
            end
            3'd3: begin  // MULHU
                prod       = za * zb;
                ref_result = prod[63:32];
            end
            3'd4: begin
                for (int k = 0; k < 2; k++) begin
                    lane_sum += int'($signed(a[16*k +: 16])) * int'($signed(b[16*k +: 16]));
                end
                ref_result = lane_sum;  // wraps mod 2^32
            end
            3'd5: begin
                for (int k = 0; k < 4; k++) begin
                    lane_sum += int'($signed(a[8*k +: 8])) * int'($signed(b[8*k +: 8]));
                end
                ref_result = {{15{lane_sum[16]}}, lane_sum[16:0]};  // 17-bit sign extend
            end
            default: ref_result = '0;  // codes 6 and 7
        endcase
    endfunction

    // corner values mixed in with random words
    function automatic simd_t pick_operand();
        case (int'($unsigned($random(seed)) % 8))
            0:       pick_operand = 32'h0000_0000;
            1:       pick_operand = 32'h0000_0001;
            2:       pick_operand = 32'hffff_ffff;
            3:       pick_operand = 32'h8000_0000;
            4:       pick_operand = 32'h7fff_ffff;
            default: pick_operand = $random(seed);
        endcase
    endfunction

    function automatic string op_name(input logic [2:0] op);
        case (op)
            3'd0:    op_name = "mul";
            3'd1:    op_name = "mulh";
            3'd2:    op_name = "mulhsu";
            3'd3:    op_name = "mulhu";
            3'd4:    op_name = "dot16";
            3'd5:    op_name = "dot8";
            default: op_name = "invalid";
        endcase
    endfunction

    task automatic check_value(input string what, input simd_t exp, input simd_t act);
        assert (act == exp) else begin
            $display("FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic finish_test(input int errs_before);
        if (errors == errs_before) begin
            pass_count++;
            $display("test %s ok", test_name);
        end else begin
            fail_count++;
            $display("test %s failed", test_name);
        end
    endtask

    // AW and W raised together and each dropped on its own handshake
    task automatic write_reg(input axi_addr_t addr, input simd_t data);
        logic aw_left;
        logic w_left;
        logic aw_hs;
        logic w_hs;
        logic seen;
        int   stall;
        @(posedge clk);
        awaddr  <= addr;
        awvalid <= 1'b1;
        wdata   <= data;
        wstrb   <= AXI_STRB_FULL;
        wvalid  <= 1'b1;
        aw_left = 1'b1;
        w_left  = 1'b1;
        while (aw_left || w_left) begin
            @(negedge clk);  // readies stable here
            aw_hs = aw_left && awready;
            w_hs  = w_left && wready;
            @(posedge clk);
            if (aw_hs) begin
                awvalid <= 1'b0;
                aw_left = 1'b0;
            end
            if (w_hs) begin
                wvalid <= 1'b0;
                w_left = 1'b0;
            end
        end
        stall = stall_en ? int'($unsigned($random(seed)) % 7) : 0;
        seen  = 1'b0;
        repeat (stall) begin
            @(negedge clk);
            assert (bvalid || !seen) else begin
                $display("%s: write response dropped before BREADY", test_name);
                errors++;
            end
            seen = seen || bvalid;
            @(posedge clk);
        end
        bready <= 1'b1;
        do @(negedge clk); while (!bvalid);
        check_value("bresp", '0, simd_t'(bresp));
        @(posedge clk);
        bready <= 1'b0;
        @(negedge clk);
        assert (!bvalid) else begin
            $display("%s: write response still valid after its handshake", test_name);
            errors++;
        end
    endtask

    task automatic read_reg(input axi_addr_t addr, output simd_t data);
        logic seen;
        int   stall;
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        do @(negedge clk); while (!arready);
        @(posedge clk);
        arvalid <= 1'b0;
        stall = stall_en ? int'($unsigned($random(seed)) % 7) : 0;
        seen  = 1'b0;
        repeat (stall) begin
            @(negedge clk);
            assert (rvalid || !seen) else begin
                $display("%s: read response dropped before RREADY", test_name);
                errors++;
            end
            seen = seen || rvalid;
            @(posedge clk);
        end
        rready <= 1'b1;
        do @(negedge clk); while (!rvalid);
        data = rdata;
        check_value("rresp", '0, simd_t'(rresp));
        @(posedge clk);
        rready <= 1'b0;
        @(negedge clk);
        assert (!rvalid) else begin
            $display("%s: read response still valid after its handshake", test_name);
            errors++;
        end
    endtask

    // poll STATUS until done is set with busy clear
    task automatic wait_done();
        simd_t status;
        int    polls;
        polls = 0;
        do begin
            read_reg(REG_STATUS, status);
            polls++;
        end while (!status[0] && polls < MAX_POLLS);
        assert (status[0]) else begin
            $display("%s: done never set after the start", test_name);
            errors++;
        end
        if (status[0]) begin
            check_value("status", 32'h1, status);
        end
    endtask

    task automatic run_op(input string name, input logic [2:0] op, input simd_t a,
                          input simd_t b);
        simd_t got;
        int    errs;
        errs      = errors;
        test_name = name;
        write_reg(REG_A, a);
        write_reg(REG_B, b);
        write_reg(REG_CTRL, simd_t'(op));
        wait_done();
        read_reg(REG_RESULT, got);
        check_value("result", ref_result(op, a, b), got);
        read_reg(REG_A, got);  // operands unchanged by the run
        check_value("reg_a", a, got);
        read_reg(REG_B, got);
        check_value("reg_b", b, got);
        finish_test(errs);
    endtask

    // second start with new operands leaves only its own result
    task automatic run_pair(input string name);
        simd_t      a1;
        simd_t      b1;
        simd_t      a2;
        simd_t      b2;
        logic [2:0] op1;
        logic [2:0] op2;
        simd_t      got;
        int         errs;
        errs      = errors;
        test_name = name;
        a1  = pick_operand();
        b1  = pick_operand();
        a2  = pick_operand();
        b2  = pick_operand();
        op1 = 3'($unsigned($random(seed)) % 6);
        op2 = 3'($unsigned($random(seed)) % 6);
        write_reg(REG_A, a1);
        write_reg(REG_B, b1);
        write_reg(REG_CTRL, simd_t'(op1));
        write_reg(REG_A, a2);
        write_reg(REG_B, b2);
        write_reg(REG_CTRL, simd_t'(op2));
        wait_done();
        read_reg(REG_RESULT, got);
        check_value("result", ref_result(op2, a2, b2), got);
        finish_test(errs);
    endtask

    // watchdog
    initial begin
        repeat (WD_CYCLES) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", WD_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        simd_t      got;
        int         errs;
        logic [2:0] op;
        seed       = 32'hc173;
        errors     = 0;
        pass_count = 0;
        fail_count = 0;
        stall_en   = 1'b0;
        i_rst   <= 1'b1;
        awaddr  <= '0;
        awvalid <= 1'b0;
        wdata   <= '0;
        wstrb   <= '0;
        wvalid  <= 1'b0;
        bready  <= 1'b0;
        araddr  <= '0;
        arvalid <= 1'b0;
        rready  <= 1'b0;
        test_name = "reset_values";
        errs      = errors;
        repeat (RST_CYCLES - 1) @(posedge clk);
        @(negedge clk);  // handshake outputs held low in reset
        assert (!awready && !wready && !bvalid && !arready && !rvalid) else begin
            $display("%s: AXI ready or valid high during reset", test_name);
            errors++;
        end
        @(posedge clk);
        i_rst <= 1'b0;

        // whole map reads zero including the holes
        for (int k = 0; k < 8; k++) begin
            read_reg(axi_addr_t'(4 * k), got);
            check_value($sformatf("addr %02h", 4 * k), '0, got);
        end
        finish_test(errs);

        for (int k = 0; k < N_SCALAR; k++) begin
            op = 3'(k % 4);
            run_op($sformatf("%s_%0d", op_name(op), k), op, pick_operand(), pick_operand());
        end
        for (int k = 0; k < N_DOT; k++) begin
            op = 3'(4 + k % 2);
            run_op($sformatf("%s_%0d", op_name(op), k), op, pick_operand(), pick_operand());
        end
        run_op("invalid_6", 3'd6, pick_operand(), pick_operand());
        run_op("invalid_7", 3'd7, pick_operand(), pick_operand());
        for (int k = 0; k < N_B2B; k++) begin
            run_pair($sformatf("back_to_back_%0d", k));
        end

        stall_en = 1'b1;  // responses now wait on the master
        for (int k = 0; k < N_STALL; k++) begin
            op = 3'($unsigned($random(seed)) % 6);
            run_op($sformatf("stall_%s_%0d", op_name(op), k), op, pick_operand(),
                   pick_operand());
        end

        $display("tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
mult_pkg.sv
mult_if.sv
csa_tree_8.sv
simd_mult.sv
mult_axil_regs.sv
mult_top.sv
tb_mult_top.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, then search the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -f src.f --top-module tb_mult_top \
    -Mdir "$OBJ" -o tb_mult_top
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$OBJ/tb_mult_top" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTBENCH PASSED" "$LOG"; then
    echo "simulation result: pass"
    exit 0
fi
echo "simulation result: fail, see $LOG"
exit 1
